/* list.f */
+incdir+.
pu_bus_pkg.sv
spi_link_pkg.sv
spi_bounce_filter.sv
spi_word_buffer.sv
spi_word_splitter.sv
spi_slave_shifter.sv
pu_slave_spi.sv
tb_clock_gen.sv
tb_pu_slave_spi.sv

/* pu_bus_pkg.sv */
`include "spi_slave_macros.svh"

// types seen on the processing unit side of the port
package pu_bus_pkg;

    // one data word from the unit
    typedef logic [`PU_DATA_WIDTH-1:0] pu_word_t;

    // number of words in one bank, 0 up to PU_BUF_SIZE inclusive
    typedef logic [$clog2(`PU_BUF_SIZE + 1)-1:0] pu_count_t;

endpackage

/* pu_slave_spi.sv */
`timescale 1ns/100ps

`include "spi_slave_macros.svh"

module pu_slave_spi
    import pu_bus_pkg::*;
    import spi_link_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     cycle,
    input  logic     wr,
    input  pu_word_t data,
    output logic     flag_stop,
    input  logic     cs,
    input  logic     sclk,
    input  logic     mosi,
    output logic     miso
);

    logic      f_cs;
    logic      f_sclk;
    logic      cs_prev;
    logic      swap;
    logic      word_take;
    logic      empty;
    logic      byte_take;
    pu_word_t  buf_word;
    spi_byte_t spi_byte;

    //////////////////////////////
    // input filters
    //////////////////////////////

    spi_bounce_filter #(.DEPTH(`PU_BOUNCE_FILTER)) cs_filter (
        .clk(clk), .rst(rst), .raw(cs), .init(1'b1), .filtered(f_cs)
    );

    spi_bounce_filter #(.DEPTH(`PU_BOUNCE_FILTER)) sclk_filter (
        .clk(clk), .rst(rst), .raw(sclk), .init(1'b0), .filtered(f_sclk)
    );

    // receive data is not stored yet
    spi_bounce_filter #(.DEPTH(`PU_BOUNCE_FILTER)) mosi_filter (
        .clk(clk), .rst(rst), .raw(mosi), .init(1'b0), .filtered()
    );

    //////////////////////////////
    // control
    //////////////////////////////

    // banks may only swap between transactions
    assign swap = cycle && f_cs;

    // one cycle pulse on the rising edge of cs
    always_ff @(posedge clk) begin
        if (rst) begin
            cs_prev   <= 1'b1;
            flag_stop <= 1'b0;
        end else begin
            cs_prev   <= f_cs;
            flag_stop <= !cs_prev && f_cs;
        end
    end

    //////////////////////////////
    // datapath
    //////////////////////////////

    spi_word_buffer word_buffer (
        .clk(clk), .rst(rst), .wr(wr), .data(data), .swap(swap), .clear(flag_stop),
        .word_take(word_take), .word(buf_word), .empty(empty)
    );

    spi_word_splitter word_splitter (
        .clk(clk), .rst(rst), .clear(flag_stop), .byte_take(byte_take), .word(buf_word),
        .empty(empty), .word_take(word_take), .byte_out(spi_byte)
    );

    spi_slave_shifter shifter (
        .clk(clk), .rst(rst), .cs(f_cs), .sclk(f_sclk), .byte_in(spi_byte),
        .byte_take(byte_take), .miso(miso)
    );

endmodule

/* run_sim.sh */
#!/bin/sh
# compile and run the spi slave testbench with verilator

TOP=tb_pu_slave_spi
LOG=sim.log

rm -rf obj_dir "$LOG"

verilator --binary --timing -Wno-fatal --top-module "$TOP" -f list.f -o "$TOP" \
    && "./obj_dir/$TOP" > "$LOG" 2>&1 \
    || echo "simulation did not complete" >> "$LOG"

cat "$LOG"

grep -q "Finished with errors" "$LOG" && { echo "RESULT: FAIL"; exit 1; }
grep -q "Finished with no errors" "$LOG" || { echo "RESULT: FAIL"; exit 1; }
echo "RESULT: PASS"

/* spi_bounce_filter.sv */
`timescale 1ns/100ps

`include "spi_slave_macros.svh"

module spi_bounce_filter #(
    parameter int DEPTH = `PU_BOUNCE_FILTER
) (
    input  logic clk,
    input  logic rst,
    input  logic raw,
    input  logic init,
    output logic filtered
);

    localparam int CNT_W = $clog2(DEPTH + 1);

    logic             raw_q;
    logic [CNT_W-1:0] cnt;

    // raw pin is registered once, then must hold for DEPTH samples
    always_ff @(posedge clk) begin
        if (rst) begin
            raw_q    <= init;
            filtered <= init;
            cnt      <= '0;
        end else begin
            raw_q <= raw;
            if (raw_q == filtered) begin
                // any bounce back restarts the count
                cnt <= '0;
            end else if (cnt == CNT_W'(DEPTH - 1)) begin
                filtered <= raw_q;
                cnt      <= '0;
            end else begin
                cnt <= cnt + 1'b1;
            end
        end
    end

endmodule

/* spi_link_pkg.sv */
`include "spi_slave_macros.svh"

// types of the serial byte stream
package spi_link_pkg;

    import pu_bus_pkg::*;

    // one byte as shifted out on miso
    typedef logic [`PU_SPI_WIDTH-1:0] spi_byte_t;

    // position of a byte inside a word, 3 is the msb
    typedef logic [$clog2(`PU_BYTES_PER_WORD)-1:0] byte_index_t;

    // a word loaded whole and read back byte by byte
    typedef union packed {
        pu_word_t                                word;
        spi_byte_t [`PU_BYTES_PER_WORD-1:0]      bytes;
    } spi_word_bytes_u;

endpackage

/* spi_slave_macros.svh */
`ifndef SPI_SLAVE_MACROS_SVH
`define SPI_SLAVE_MACROS_SVH

//////////////////////////////
// word bus side
//////////////////////////////

// one word written by the processing unit
`define PU_DATA_WIDTH 32

// words held by each bank of the ping-pong buffer
`define PU_BUF_SIZE 6

//////////////////////////////
// spi side
//////////////////////////////

// one byte on the serial line
`define PU_SPI_WIDTH 8

// bytes sent per unit word, msb first
`define PU_BYTES_PER_WORD 4

// stable cycles before a filtered input follows its pin
`define PU_BOUNCE_FILTER 20

`endif

/* spi_slave_shifter.sv */
`timescale 1ns/100ps

`include "spi_slave_macros.svh"

module spi_slave_shifter
    import spi_link_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      cs,
    input  logic      sclk,
    input  spi_byte_t byte_in,
    output logic      byte_take,
    output logic      miso
);

    localparam int BIT_W = $clog2(`PU_SPI_WIDTH);
    localparam logic [BIT_W-1:0] LAST_BIT = BIT_W'(`PU_SPI_WIDTH - 1);

    logic             cs_q;
    logic             sclk_q;
    logic             cs_fall;
    logic             sclk_fall;
    logic             load;
    logic [BIT_W-1:0] bit_cnt;
    spi_byte_t        shreg;

    //////////////////////////////
    // edge detect
    //////////////////////////////

    assign cs_fall   = cs_q && !cs;
    // mode 0, data moves on the falling edge only
    assign sclk_fall = sclk_q && !sclk && !cs;

    // new byte at transaction start and after every full byte
    assign load = cs_fall || (sclk_fall && bit_cnt == LAST_BIT);

    always_ff @(posedge clk) begin
        if (rst) begin
            cs_q      <= 1'b1;
            sclk_q    <= 1'b0;
            bit_cnt   <= '0;
            byte_take <= 1'b0;
        end else begin
            cs_q      <= cs;
            sclk_q    <= sclk;
            byte_take <= load;
            if (cs || load) begin
                bit_cnt <= '0;
            end else if (sclk_fall) begin
                bit_cnt <= bit_cnt + 1'b1;
            end
        end
    end

    //////////////////////////////
    // shift register
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (load) begin
            shreg <= byte_in;
        end else if (sclk_fall) begin
            shreg <= {shreg[`PU_SPI_WIDTH-2:0], 1'b0};
        end
    end

    // line stays low while deselected
    assign miso = !cs && shreg[`PU_SPI_WIDTH-1];

endmodule

/* spi_word_buffer.sv */
`timescale 1ns/100ps

`include "spi_slave_macros.svh"

module spi_word_buffer
    import pu_bus_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     wr,
    input  pu_word_t data,
    input  logic     swap,
    input  logic     clear,
    input  logic     word_take,
    output pu_word_t word,
    output logic     empty
);

    localparam pu_count_t FULL = pu_count_t'(`PU_BUF_SIZE);

    // two banks, one filled by the unit while the other is sent
    pu_word_t  mem [2][`PU_BUF_SIZE];
    pu_count_t count [2];
    pu_count_t rd_idx [2];

    logic sel;
    logic wr_bank;
    logic rd_bank;
    logic full;
    logic push;

    //////////////////////////////
    // bank roles
    //////////////////////////////

    // sel names the write bank
    assign wr_bank = sel;
    assign rd_bank = ~sel;

    assign full  = (count[wr_bank] == FULL);
    assign empty = (rd_idx[rd_bank] == count[rd_bank]);
    assign push  = wr && !full;

    // words leave in write order
    assign word = mem[rd_bank][rd_idx[rd_bank]];

    //////////////////////////////
    // storage
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_bank][count[wr_bank]] <= data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            sel <= 1'b0;
            for (int b = 0; b < 2; b++) begin
                count[b]  <= '0;
                rd_idx[b] <= '0;
            end
        end else begin
            if (swap) begin
                sel <= ~sel;
            end
            // writes to a full bank are lost
            if (push) begin
                count[wr_bank] <= count[wr_bank] + 1'b1;
            end
            // end of transaction drops whatever was left unsent
            if (clear) begin
                count[rd_bank]  <= '0;
                rd_idx[rd_bank] <= '0;
            end else if (word_take && !empty) begin
                rd_idx[rd_bank] <= rd_idx[rd_bank] + 1'b1;
            end
        end
    end

endmodule

/* spi_word_splitter.sv */
`timescale 1ns/100ps

`include "spi_slave_macros.svh"

module spi_word_splitter
    import pu_bus_pkg::*;
    import spi_link_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      clear,
    input  logic      byte_take,
    input  pu_word_t  word,
    input  logic      empty,
    output logic      word_take,
    output spi_byte_t byte_out
);

    localparam byte_index_t MSB_IDX = byte_index_t'(`PU_BYTES_PER_WORD - 1);

    spi_word_bytes_u cur;
    byte_index_t     idx;
    logic            valid;
    logic            fetch;

    // last byte taken, or nothing real held yet
    assign fetch     = !clear && ((byte_take && idx == '0) || !valid);
    assign word_take = fetch && !empty;

    assign byte_out = cur.bytes[idx];

    // zero word stands in while the read bank is empty
    always_ff @(posedge clk) begin
        if (fetch) begin
            cur.word <= empty ? '0 : word;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            idx   <= MSB_IDX;
            valid <= 1'b0;
        end else if (clear) begin
            idx   <= MSB_IDX;
            valid <= 1'b0;
        end else begin
            if (byte_take) begin
                idx <= (idx == '0) ? MSB_IDX : idx - 1'b1;
            end
            // keeps polling until a real word is held
            if (fetch) begin
                valid <= !empty;
            end
        end
    end

endmodule

/* tb_clock_gen.sv */
`timescale 1ns/100ps

module tb_clock_gen #(
    parameter int PERIOD_NS    = 10,
    parameter int RESET_CYCLES = 3
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    // reset drops on a falling edge like every other input
    initial begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
    end

endmodule

/* tb_pu_slave_spi.sv */
`timescale 1ns/100ps

`include "spi_slave_macros.svh"

module tb_pu_slave_spi
    import pu_bus_pkg::*;
    import spi_link_pkg::*;
();

    // sclk half period is longer than the filter latency
    localparam int HALF       = `PU_BOUNCE_FILTER + 5;
    localparam int STOP_LIMIT = `PU_BOUNCE_FILTER + 5;

    logic      clk;
    logic      rst;
    logic      cycle;
    logic      wr;
    pu_word_t  data;
    logic      flag_stop;
    logic      cs;
    logic      sclk;
    logic      mosi;
    logic      miso;

    logic [31:0] rng_state;
    int          stop_seen;
    spi_byte_t   exp_bytes [$];

    tb_clock_gen clock_gen (.clk(clk), .rst(rst));

    pu_slave_spi dut (
        .clk(clk), .rst(rst), .cycle(cycle), .wr(wr), .data(data), .flag_stop(flag_stop),
        .cs(cs), .sclk(sclk), .mosi(mosi), .miso(miso)
    );

    //////////////////////////////
    // helpers
    //////////////////////////////

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] s;
        s = x ^ (x << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    // expected stream with the msb byte first
    function automatic void push_word(input pu_word_t w);
        for (int k = `PU_BYTES_PER_WORD - 1; k >= 0; k--) begin
            exp_bytes.push_back(spi_byte_t'(w >> (k * `PU_SPI_WIDTH)));
        end
    endfunction

    task automatic stop_on_error();
        $display("Finished with errors");
        $fatal(1, "stopped at the first error");
    endtask

    // counts stop pulses while waiting
    task automatic idle(input int n);
        repeat (n) begin
            @(negedge clk);
            if (flag_stop) begin
                stop_seen++;
            end
        end
    endtask

    task automatic wait_reset();
        int n;
        for (n = 0; n < 20; n++) begin
            @(posedge clk);
            if (!rst) begin
                break;
            end
        end
        assert (!rst) else begin
            $display("reset was never released");
            stop_on_error();
        end
        @(negedge clk);
    endtask

    task automatic write_word(input pu_word_t w);
        wr   = 1'b1;
        data = w;
        idle(1);
        wr   = 1'b0;
    endtask

    task automatic pulse_cycle();
        cycle = 1'b1;
        idle(1);
        cycle = 1'b0;
        idle(4);
    endtask

    task automatic start_transfer();
        cs = 1'b0;
        idle(HALF);
    endtask

    // raise cs and expect a single stop pulse
    task automatic close_transfer();
        int  waited;
        bit  seen;
        seen = 1'b0;
        cs   = 1'b1;
        for (waited = 0; waited < STOP_LIMIT; waited++) begin
            @(negedge clk);
            if (flag_stop) begin
                seen = 1'b1;
                break;
            end
        end
        assert (seen) else begin
            $display("flag_stop did not rise within %0d cycles after cs went high", STOP_LIMIT);
            stop_on_error();
        end
        @(negedge clk);
        assert (!flag_stop) else begin
            $display("Error: flag_stop is 0x%0h one cycle after its pulse, expected 0x0",
                     flag_stop);
            stop_on_error();
        end
        idle(4);
    endtask

    task automatic sclk_glitch();
        sclk = 1'b1;
        idle(`PU_BOUNCE_FILTER / 2);
        sclk = 1'b0;
        idle(HALF);
    endtask

    task automatic cs_glitch();
        cs = 1'b1;
        idle(`PU_BOUNCE_FILTER - 3);
        cs = 1'b0;
        idle(HALF);
    endtask

    // mode 0 master samples miso right before each rising sclk
    task automatic read_byte(output spi_byte_t b, input bit glitch);
        b = '0;
        for (int i = 0; i < `PU_SPI_WIDTH; i++) begin
            b    = {b[`PU_SPI_WIDTH-2:0], miso};
            mosi = i[0];
            sclk = 1'b1;
            idle(HALF);
            sclk = 1'b0;
            idle(HALF);
            if (glitch && i == 2) begin
                sclk_glitch();
            end
            if (glitch && i == 5) begin
                cs_glitch();
            end
        end
    endtask

    // missing expected bytes mean zero bytes
    task automatic read_and_check(input string tag, input int count, input bit glitch);
        spi_byte_t got;
        spi_byte_t want;
        for (int n = 0; n < count; n++) begin
            read_byte(got, glitch);
            if (exp_bytes.size() > 0) begin
                want = exp_bytes.pop_front();
            end else begin
                want = '0;
            end
            assert (got == want) else begin
                $display("Error: miso byte %0d (%s) is 0x%02h, expected 0x%02h",
                         n, tag, got, want);
                stop_on_error();
            end
        end
    endtask

    //////////////////////////////
    // directed tests
    //////////////////////////////

    task automatic reset_values();
        assert (miso == 1'b0) else begin
            $display("Error: miso is 0x%0h after reset, expected 0x0", miso);
            stop_on_error();
        end
        assert (flag_stop == 1'b0) else begin
            $display("Error: flag_stop is 0x%0h after reset, expected 0x0", flag_stop);
            stop_on_error();
        end
    endtask

    task automatic word_order();
        exp_bytes.delete();
        for (int i = 0; i < 3; i++) begin
            rng_state = xorshift32(rng_state);
            write_word(rng_state);
            push_word(rng_state);
        end
        pulse_cycle();
        start_transfer();
        read_and_check("word order", 12, 1'b0);
    endtask

    task automatic end_of_transaction();
        exp_bytes.delete();
        close_transfer();
        // one word stays in the splitter and one in the read bank
        for (int i = 0; i < 3; i++) begin
            rng_state = xorshift32(rng_state);
            write_word(rng_state);
            if (i == 0) begin
                push_word(rng_state);
            end
        end
        pulse_cycle();
        start_transfer();
        read_and_check("partial read", 4, 1'b0);
        close_transfer();
        // read bank was cleared
        start_transfer();
        read_and_check("after clear", 8, 1'b0);
        close_transfer();
    endtask

    task automatic bank_protection();
        pu_word_t late [$];
        exp_bytes.delete();
        // a word already waiting would show up at once after a wrong swap
        rng_state = xorshift32(rng_state);
        write_word(rng_state);
        late.push_back(rng_state);
        start_transfer();
        pulse_cycle();
        for (int i = 0; i < 2; i++) begin
            rng_state = xorshift32(rng_state);
            write_word(rng_state);
            late.push_back(rng_state);
        end
        read_and_check("no swap", 8, 1'b0);
        close_transfer();
        pulse_cycle();
        foreach (late[i]) begin
            push_word(late[i]);
        end
        start_transfer();
        read_and_check("late swap", 16, 1'b0);
        close_transfer();
    endtask

    task automatic full_bank();
        exp_bytes.delete();
        for (int i = 0; i < `PU_BUF_SIZE + 2; i++) begin
            rng_state = xorshift32(rng_state);
            write_word(rng_state);
            if (i < `PU_BUF_SIZE) begin
                push_word(rng_state);
            end
        end
        pulse_cycle();
        start_transfer();
        read_and_check("full bank", (`PU_BUF_SIZE + 1) * `PU_BYTES_PER_WORD, 1'b0);
        close_transfer();
    endtask

    task automatic glitch_filtering();
        exp_bytes.delete();
        for (int i = 0; i < 2; i++) begin
            rng_state = xorshift32(rng_state);
            write_word(rng_state);
            push_word(rng_state);
        end
        pulse_cycle();
        stop_seen = 0;
        start_transfer();
        read_and_check("glitches", 8, 1'b1);
        assert (stop_seen == 0) else begin
            $display("flag_stop rose during a transfer that only had short cs pulses");
            stop_on_error();
        end
        close_transfer();
    endtask

    initial begin
        cycle     = 1'b0;
        wr        = 1'b0;
        data      = '0;
        cs        = 1'b1;
        sclk      = 1'b0;
        mosi      = 1'b0;
        rng_state = 32'h764e_c209;
        stop_seen = 0;
        wait_reset();
        reset_values();
        word_order();
        end_of_transaction();
        bank_protection();
        full_bank();
        glitch_filtering();
        $display("Finished with no errors");
        $finish;
    end

endmodule
